//--- src/soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [7:0]  byte_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // address map
    localparam addr_t SRAM_BASE      = 32'h8000_0000;
    localparam int    SRAM_WORDS     = 256;
    localparam addr_t UART_DATA_ADDR = 32'ha000_03f8;
    localparam addr_t UART_STAT_ADDR = 32'ha000_03fc;

    // uart line and fifo
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_FIFO_DEPTH   = 4;

    typedef logic [$clog2(SRAM_WORDS)-1:0]        sram_idx_t;
    typedef logic [$clog2(UART_CLKS_PER_BIT)-1:0] baud_cnt_t;
    typedef logic [$clog2(UART_FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(UART_FIFO_DEPTH):0]     fifo_cnt_t;

    // everything a master drives
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } axi_req_t;

    // everything a slave drives
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } axi_rsp_t;

endpackage

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire                 clk,
    input  wire                 rst,
    input  wire soc_pkg::axi_req_t ifu_req,
    output soc_pkg::axi_rsp_t   ifu_rsp,
    input  wire soc_pkg::axi_req_t lsu_req,
    output soc_pkg::axi_rsp_t   lsu_rsp,
    output soc_pkg::axi_req_t   bus_req,
    input  wire soc_pkg::axi_rsp_t bus_rsp
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_IFU,
        ARB_LSU
    } arb_state_t;

    arb_state_t state;
    logic       last_lsu;
    logic       ifu_want;
    logic       lsu_want;
    logic       done;

    // a master wants the bus as soon as it shows an address
    assign ifu_want = ifu_req.arvalid | ifu_req.awvalid;
    assign lsu_want = lsu_req.arvalid | lsu_req.awvalid;

    assign done = (bus_rsp.bvalid & bus_req.bready) | (bus_rsp.rvalid & bus_req.rready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ARB_IDLE;
            last_lsu <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // on a tie the master not served last wins
                    if (ifu_want && (!lsu_want || last_lsu)) begin
                        state    <= ARB_IFU;
                        last_lsu <= 1'b0;
                    end else if (lsu_want) begin
                        state    <= ARB_LSU;
                        last_lsu <= 1'b1;
                    end
                end
                default: begin
                    if (done) begin
                        state <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // only the owner sees the bus
    always_comb begin
        bus_req = '0;
        ifu_rsp = '0;
        lsu_rsp = '0;
        case (state)
            ARB_IFU: begin
                bus_req = ifu_req;
                ifu_rsp = bus_rsp;
            end
            ARB_LSU: begin
                bus_req = lsu_req;
                lsu_rsp = bus_rsp;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire                    clk,
    input  wire                    rst,
    input  wire soc_pkg::axi_req_t bus_req,
    output soc_pkg::axi_rsp_t      bus_rsp,
    output soc_pkg::axi_req_t      sram_req,
    input  wire soc_pkg::axi_rsp_t sram_rsp,
    output soc_pkg::axi_req_t      uart_req,
    input  wire soc_pkg::axi_rsp_t uart_rsp
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_UART,
        TGT_ERR
    } tgt_t;

    typedef enum logic [2:0] {
        ERR_IDLE,
        ERR_WAIT_W,
        ERR_WAIT_AW,
        ERR_BRESP,
        ERR_RRESP
    } err_state_t;

    function automatic tgt_t decode(input addr_t a);
        addr_t offs;
        offs = a - SRAM_BASE;
        if (offs < addr_t'(SRAM_WORDS * 4)) begin
            return TGT_SRAM;
        end
        if (a == UART_DATA_ADDR || a == UART_STAT_ADDR) begin
            return TGT_UART;
        end
        return TGT_ERR;
    endfunction

    addr_t      dec_addr;
    tgt_t       dec_tgt;
    tgt_t       tgt_q;
    tgt_t       tgt;
    logic       tgt_held;
    logic       addr_hs;
    logic       done;
    err_state_t err_state;
    axi_req_t   err_req;
    axi_rsp_t   err_rsp;

    assign dec_addr = bus_req.arvalid ? bus_req.araddr : bus_req.awaddr;
    assign dec_tgt  = decode(dec_addr);
    // the latched target wins once the address has been taken
    assign tgt      = tgt_held ? tgt_q : dec_tgt;

    assign addr_hs = (bus_req.arvalid & bus_rsp.arready)
                   | (bus_req.awvalid & bus_rsp.awready);
    assign done    = (bus_rsp.bvalid & bus_req.bready)
                   | (bus_rsp.rvalid & bus_req.rready);

    always_ff @(posedge clk) begin
        if (rst) begin
            tgt_held <= 1'b0;
        end else if (done) begin
            tgt_held <= 1'b0;
        end else if (addr_hs && !tgt_held) begin
            tgt_held <= 1'b1;
            tgt_q    <= dec_tgt;
        end
    end

    always_comb begin
        sram_req = '0;
        uart_req = '0;
        err_req  = '0;
        case (tgt)
            TGT_SRAM: begin
                sram_req = bus_req;
                bus_rsp  = sram_rsp;
            end
            TGT_UART: begin
                uart_req = bus_req;
                bus_rsp  = uart_rsp;
            end
            default: begin
                err_req = bus_req;
                bus_rsp = err_rsp;
            end
        endcase
    end

    // error responder for unmapped addresses
    always_ff @(posedge clk) begin
        if (rst) begin
            err_state <= ERR_IDLE;
        end else begin
            case (err_state)
                ERR_IDLE: begin
                    if (err_req.arvalid) begin
                        err_state <= ERR_RRESP;
                    end else if (err_req.awvalid && err_req.wvalid) begin
                        err_state <= ERR_BRESP;
                    end else if (err_req.awvalid) begin
                        err_state <= ERR_WAIT_W;
                    end else if (err_req.wvalid) begin
                        err_state <= ERR_WAIT_AW;
                    end
                end
                ERR_WAIT_W: begin
                    if (err_req.wvalid) begin
                        err_state <= ERR_BRESP;
                    end
                end
                ERR_WAIT_AW: begin
                    if (err_req.awvalid) begin
                        err_state <= ERR_BRESP;
                    end
                end
                ERR_BRESP: begin
                    if (err_req.bready) begin
                        err_state <= ERR_IDLE;
                    end
                end
                default: begin
                    if (err_req.rready) begin
                        err_state <= ERR_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        err_rsp         = '0;
        err_rsp.arready = (err_state == ERR_IDLE);
        err_rsp.awready = (err_state == ERR_IDLE) || (err_state == ERR_WAIT_AW);
        err_rsp.wready  = (err_state == ERR_IDLE) || (err_state == ERR_WAIT_W);
        err_rsp.bvalid  = (err_state == ERR_BRESP);
        err_rsp.bresp   = RESP_DECERR;
        err_rsp.rvalid  = (err_state == ERR_RRESP);
        err_rsp.rresp   = RESP_DECERR;
    end

endmodule

`default_nettype wire

//--- src/sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_slave (
    input  wire                    clk,
    input  wire                    rst,
    input  wire soc_pkg::axi_req_t req,
    output soc_pkg::axi_rsp_t      rsp
);

    import soc_pkg::*;

    data_t     mem [SRAM_WORDS];
    logic      aw_held;
    logic      w_held;
    logic      bvalid;
    logic      rvalid;
    sram_idx_t awidx_q;
    data_t     wdata_q;
    strb_t     wstrb_q;
    data_t     rdata_q;
    logic      aw_hs;
    logic      w_hs;
    logic      ar_hs;
    logic      wr_go;
    sram_idx_t wr_idx;
    data_t     wr_data;
    strb_t     wr_strb;

    assign aw_hs = req.awvalid & rsp.awready;
    assign w_hs  = req.wvalid & rsp.wready;
    assign ar_hs = req.arvalid & rsp.arready;

    // write once address and data are both here, in either order
    assign wr_go   = (aw_held | aw_hs) & (w_held | w_hs) & ~bvalid;
    assign wr_idx  = aw_held ? awidx_q : req.awaddr[2 +: $bits(sram_idx_t)];
    assign wr_data = w_held ? wdata_q : req.wdata;
    assign wr_strb = w_held ? wstrb_q : req.wstrb;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (wr_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (aw_hs) begin
                    aw_held <= 1'b1;
                end
                if (w_hs) begin
                    w_held <= 1'b1;
                end
                if (bvalid && req.bready) begin
                    bvalid <= 1'b0;
                end
            end
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awidx_q <= req.awaddr[2 +: $bits(sram_idx_t)];
        end
        if (w_hs) begin
            wdata_q <= req.wdata;
            wstrb_q <= req.wstrb;
        end
        if (wr_go) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
        if (ar_hs) begin
            rdata_q <= mem[req.araddr[2 +: $bits(sram_idx_t)]];
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = ~aw_held & ~bvalid;
        rsp.wready  = ~w_held & ~bvalid;
        rsp.bvalid  = bvalid;
        rsp.bresp   = RESP_OKAY;
        rsp.arready = ~rvalid;
        rsp.rvalid  = rvalid;
        rsp.rdata   = rdata_q;
        rsp.rresp   = RESP_OKAY;
    end

endmodule

`default_nettype wire

//--- src/uart_slave.sv
`timescale 1ns/1ps
`default_nettype none

module uart_slave (
    input  wire                    clk,
    input  wire                    rst,
    input  wire soc_pkg::axi_req_t req,
    output soc_pkg::axi_rsp_t      rsp,
    output soc_pkg::byte_t         tx_data,
    output logic                   tx_valid,
    input  wire                    tx_ready,
    input  wire                    tx_busy
);

    import soc_pkg::*;

    logic      awready;
    logic      wready;
    logic      aw_hand;
    logic      w_hand;
    logic      bvalid;
    addr_t     waddr;
    byte_t     wbyte;
    logic      arready;
    logic      rvalid;
    data_t     rdata;
    byte_t     fifo_mem [UART_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      is_data;
    logic      room;
    logic      join_ok;
    logic      push;
    logic      pop;

    assign is_data = (waddr == UART_DATA_ADDR);
    assign room    = (count != fifo_cnt_t'(UART_FIFO_DEPTH));
    // status writes never wait for fifo room
    assign join_ok = aw_hand & w_hand & (room | ~is_data);
    assign push    = join_ok & is_data;
    assign pop     = tx_valid & tx_ready;

    assign tx_valid = (count != '0);
    assign tx_data  = fifo_mem[rd_ptr];

    // aw and w held apart until both arrived, ready again after b
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b1;
            wready  <= 1'b1;
            aw_hand <= 1'b0;
            w_hand  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (req.awvalid && awready) begin
                awready <= 1'b0;
                aw_hand <= 1'b1;
                waddr   <= req.awaddr;
            end
            if (req.wvalid && wready) begin
                wready <= 1'b0;
                w_hand <= 1'b1;
                wbyte  <= req.wdata[7:0];
            end
            if (join_ok) begin
                aw_hand <= 1'b0;
                w_hand  <= 1'b0;
                bvalid  <= 1'b1;
            end else if (bvalid && req.bready) begin
                bvalid  <= 1'b0;
                awready <= 1'b1;
                wready  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= wbyte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // status is busy flag over fifo count, data reads as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (req.arvalid && arready) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= (req.araddr == UART_STAT_ADDR) ? data_t'({tx_busy, count}) : '0;
        end else if (rvalid && req.rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = awready;
        rsp.wready  = wready;
        rsp.bvalid  = bvalid;
        rsp.bresp   = RESP_OKAY;
        rsp.arready = arready;
        rsp.rvalid  = rvalid;
        rsp.rdata   = rdata;
        rsp.rresp   = RESP_OKAY;
    end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                 clk,
    input  wire                 rst,
    input  wire soc_pkg::byte_t tx_data,
    input  wire                 tx_valid,
    output logic                tx_ready,
    output logic                tx_busy,
    output logic                txd
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t  state;
    baud_cnt_t  cnt;
    logic [2:0] bit_idx;
    byte_t      shreg;
    logic       bit_end;

    assign bit_end  = (cnt == baud_cnt_t'(UART_CLKS_PER_BIT - 1));
    assign tx_ready = (state == TX_IDLE);
    assign tx_busy  = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            // bit period counter restarts with every line bit
            cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (tx_valid) begin
                        state <= TX_START;
                        shreg <= tx_data;
                        txd   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        txd     <= shreg[0];
                        shreg   <= shreg >> 1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shreg[0];
                            shreg   <= shreg >> 1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire soc_pkg::axi_req_t ifu_req,
    output soc_pkg::axi_rsp_t      ifu_rsp,
    input  wire soc_pkg::axi_req_t lsu_req,
    output soc_pkg::axi_rsp_t      lsu_rsp,
    output logic                   uart_txd
);

    import soc_pkg::*;

    axi_req_t bus_req;
    axi_rsp_t bus_rsp;
    axi_req_t sram_req;
    axi_rsp_t sram_rsp;
    axi_req_t uart_req;
    axi_rsp_t uart_rsp;
    byte_t    tx_data;
    logic     tx_valid;
    logic     tx_ready;
    logic     tx_busy;

    bus_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .ifu_req (ifu_req),
        .ifu_rsp (ifu_rsp),
        .lsu_req (lsu_req),
        .lsu_rsp (lsu_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    bus_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .sram_req (sram_req),
        .sram_rsp (sram_rsp),
        .uart_req (uart_req),
        .uart_rsp (uart_rsp)
    );

    sram_slave u_sram (
        .clk (clk),
        .rst (rst),
        .req (sram_req),
        .rsp (sram_rsp)
    );

    uart_slave u_uart (
        .clk      (clk),
        .rst      (rst),
        .req      (uart_req),
        .rsp      (uart_rsp),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_busy  (tx_busy)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_busy  (tx_busy),
        .txd      (uart_txd)
    );

endmodule

`default_nettype wire

//--- tb/soc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module soc_checker (
    input wire                    clk,
    input wire                    rst,
    input wire soc_pkg::axi_req_t ifu_req,
    input wire soc_pkg::axi_rsp_t ifu_rsp,
    input wire soc_pkg::axi_req_t lsu_req,
    input wire soc_pkg::axi_rsp_t lsu_rsp,
    input wire                    uart_txd
);

    // a pending address or data beat keeps its payload
    ifu_ar_stable: assert property (@(posedge clk) disable iff (rst)
        ifu_req.arvalid && !ifu_rsp.arready |=> ifu_req.arvalid && $stable(ifu_req.araddr))
        else $error("ifu ar channel changed before acceptance");

    lsu_ar_stable: assert property (@(posedge clk) disable iff (rst)
        lsu_req.arvalid && !lsu_rsp.arready |=> lsu_req.arvalid && $stable(lsu_req.araddr))
        else $error("lsu ar channel changed before acceptance");

    lsu_aw_stable: assert property (@(posedge clk) disable iff (rst)
        lsu_req.awvalid && !lsu_rsp.awready |=> lsu_req.awvalid && $stable(lsu_req.awaddr))
        else $error("lsu aw channel changed before acceptance");

    lsu_w_stable: assert property (@(posedge clk) disable iff (rst)
        lsu_req.wvalid && !lsu_rsp.wready |=> lsu_req.wvalid && $stable(lsu_req.wdata)
        && $stable(lsu_req.wstrb))
        else $error("lsu w channel changed before acceptance");

    // only the owner of the bus sees a response
    one_response: assert property (@(posedge clk) disable iff (rst)
        !((ifu_rsp.rvalid || ifu_rsp.bvalid) && (lsu_rsp.rvalid || lsu_rsp.bvalid)))
        else $error("both masters see a response on the same clock");

    line_idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> uart_txd)
        else $error("uart line not idle after reset");

endmodule

bind soc_top soc_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .ifu_req  (ifu_req),
    .ifu_rsp  (ifu_rsp),
    .lsu_req  (lsu_req),
    .lsu_rsp  (lsu_rsp),
    .uart_txd (uart_txd)
);

`default_nettype wire

//--- tb/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

    import soc_pkg::*;

    localparam int IFU_N     = 150;
    localparam int LSU_N     = 250;
    localparam int WORST_TXN = 100;
    // a burst op can issue up to six writes, each may wait on a full fifo
    localparam int LIMIT     = (IFU_N + 6 * LSU_N + SRAM_WORDS) * WORST_TXN;

    logic     clk;
    logic     rst;
    axi_req_t req [2];
    axi_rsp_t rsp [2];
    logic     uart_txd;

    data_t shadow [SRAM_WORDS];
    byte_t exp_bytes [$];
    int    checks [6];
    int    errors [6];
    int    completions;
    int    cycles;
    logic  init_done;
    logic  line_prev;

    soc_top DUT (
        .clk      (clk),
        .rst      (rst),
        .ifu_req  (req[0]),
        .ifu_rsp  (rsp[0]),
        .lsu_req  (req[1]),
        .lsu_rsp  (rsp[1]),
        .uart_txd (uart_txd)
    );

    always #4 clk = ~clk;

    task automatic check(input int t, input string name, input logic [31:0] exp,
                         input logic [31:0] act);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // count how many other transactions finished while this one waited
    task automatic note_completion(input int start);
        check(5, "grant_wait_le_1", 1, (completions - start) <= 1);
        completions++;
    endtask

    // called right after a rising edge
    task automatic bus_read(input int m, input addr_t a, output data_t d, output resp_t r);
        logic ar_ok;
        logic fin;
        int   start;
        start = completions;
        ar_ok = 1'b0;
        fin   = 1'b0;
        req[m].araddr  <= a;
        req[m].arvalid <= 1'b1;
        req[m].rready  <= 1'b0;
        while (!fin) begin
            @(negedge clk);
            if (req[m].arvalid && rsp[m].arready) begin
                ar_ok = 1'b1;
            end
            if (rsp[m].rvalid && req[m].rready) begin
                d   = rsp[m].rdata;
                r   = rsp[m].rresp;
                fin = 1'b1;
            end
            @(posedge clk);
            if (ar_ok) begin
                req[m].arvalid <= 1'b0;
            end
            req[m].rready <= fin ? 1'b0 : (($urandom % 4) != 0);
        end
        note_completion(start);
    endtask

    task automatic bus_write(input int m, input addr_t a, input data_t d, input strb_t s,
                             output resp_t r);
        logic aw_ok;
        logic w_ok;
        logic fin;
        int   start;
        start = completions;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        fin   = 1'b0;
        req[m].awaddr  <= a;
        req[m].awvalid <= 1'b1;
        req[m].wdata   <= d;
        req[m].wstrb   <= s;
        req[m].wvalid  <= 1'b1;
        req[m].bready  <= 1'b0;
        while (!fin) begin
            @(negedge clk);
            if (req[m].awvalid && rsp[m].awready) begin
                aw_ok = 1'b1;
            end
            if (req[m].wvalid && rsp[m].wready) begin
                w_ok = 1'b1;
            end
            if (rsp[m].bvalid && req[m].bready) begin
                r   = rsp[m].bresp;
                fin = 1'b1;
            end
            @(posedge clk);
            if (aw_ok) begin
                req[m].awvalid <= 1'b0;
            end
            if (w_ok) begin
                req[m].wvalid <= 1'b0;
            end
            req[m].bready <= fin ? 1'b0 : (($urandom % 4) != 0);
        end
        note_completion(start);
    endtask

    task automatic shadow_write(input int idx, input data_t d, input strb_t s);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                shadow[idx][8*i +: 8] = d[8*i +: 8];
            end
        end
    endtask

    task automatic sram_write(input int t, input int idx, input data_t d, input strb_t s);
        resp_t r;
        bus_write(1, SRAM_BASE + addr_t'(idx * 4), d, s, r);
        check(t, "sram_bresp", RESP_OKAY, r);
        shadow_write(idx, d, s);
    endtask

    task automatic sram_read(input int m);
        int    idx;
        data_t d;
        resp_t r;
        idx = $urandom % SRAM_WORDS;
        bus_read(m, SRAM_BASE + addr_t'(idx * 4), d, r);
        check(1, "sram_rresp", RESP_OKAY, r);
        check(1, "sram_rdata", shadow[idx], d);
    endtask

    task automatic uart_write(input int t);
        byte_t b;
        resp_t r;
        b = byte_t'($urandom);
        bus_write(1, UART_DATA_ADDR, {24'h0, b}, 4'hf, r);
        check(t, "uart_bresp", RESP_OKAY, r);
        exp_bytes.push_back(b);
    endtask

    task automatic lsu_op();
        int    kind;
        data_t d;
        resp_t r;
        addr_t bad;
        kind = $urandom % 16;
        bad  = 32'h1000_0000 | ((addr_t'($urandom) & 32'hffff) << 2);
        if (kind < 6) begin
            sram_write(1, $urandom % SRAM_WORDS, $urandom, strb_t'($urandom));
        end else if (kind < 10) begin
            sram_read(1);
        end else if (kind < 12) begin
            uart_write(3);
        end else if (kind == 12) begin
            repeat (UART_FIFO_DEPTH + 1 + ($urandom % 2)) uart_write(4);
        end else if (kind == 13) begin
            bus_read(1, UART_STAT_ADDR, d, r);
            check(4, "status_rresp", RESP_OKAY, r);
            check(4, "status_count_le_4", 1, d[2:0] <= 3'd4);
            check(4, "status_upper_bits", 0, d[31:4]);
        end else if (kind == 14) begin
            bus_read(1, bad, d, r);
            check(2, "decerr_rresp", RESP_DECERR, r);
            check(2, "decerr_rdata", 0, d);
        end else begin
            bus_write(1, bad, $urandom, 4'hf, r);
            check(2, "decerr_bresp", RESP_DECERR, r);
        end
    endtask

    task automatic lsu_driver();
        // every word gets a known value before fetches start
        for (int i = 0; i < SRAM_WORDS; i++) begin
            sram_write(1, i, $urandom, 4'hf);
        end
        init_done = 1'b1;
        for (int n = 0; n < LSU_N; n++) begin
            repeat ($urandom % 4) @(posedge clk);
            lsu_op();
        end
    endtask

    task automatic ifu_driver();
        while (!init_done) begin
            @(posedge clk);
        end
        for (int n = 0; n < IFU_N; n++) begin
            repeat ($urandom % 3) @(posedge clk);
            sram_read(0);
        end
    endtask

    // samples mid-bit, half a clock after each txd update
    task automatic recv_byte();
        byte_t b;
        repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
        check(3, "uart_start_bit", 0, uart_txd);
        for (int i = 0; i < 8; i++) begin
            repeat (UART_CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_txd;
        end
        repeat (UART_CLKS_PER_BIT) @(negedge clk);
        check(3, "uart_stop_bit", 1, uart_txd);
        if (exp_bytes.size() == 0) begin
            errors[3]++;
            $display("uart line sent byte %h at %0t with none expected", b, $time);
        end else begin
            check(3, "uart_byte", exp_bytes.pop_front(), b);
        end
    endtask

    always begin
        @(negedge clk);
        if (!rst && line_prev && !uart_txd) begin
            recv_byte();
        end
        line_prev = uart_txd;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("run did not finish within %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        string names [6];
        int    total_checks;
        int    total_errors;
        names = '{"", "sram data", "decode errors", "uart transmission",
                  "uart back-pressure", "fair sharing"};
        void'($urandom(32'he00f_2cfe));
        clk         = 1'b0;
        rst         = 1'b1;
        req[0]      = '0;
        req[1]      = '0;
        init_done   = 1'b0;
        line_prev   = 1'b1;
        completions = 0;
        cycles      = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fork
            ifu_driver();
            lsu_driver();
        join
        // let the serializer drain
        while (exp_bytes.size() != 0) begin
            @(negedge clk);
        end
        repeat (4 * UART_CLKS_PER_BIT) @(negedge clk);
        total_checks = 0;
        total_errors = 0;
        for (int t = 1; t < 6; t++) begin
            $display("test %0d %s: %0d checks, %0d errors", t, names[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/soc_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/sram_slave.sv
src/uart_slave.sv
src/uart_tx.sv
src/soc_top.sv
tb/soc_checker.sv
tb/tb_soc.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_soc -Mdir obj_dir -o tb_soc
	./obj_dir/tb_soc | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
